//--- verilog/pe_ctrl_pkg.sv
`default_nettype none

package pe_ctrl_pkg;

    // array limits of one processing element
    localparam int MAX_LAYERS   = 4;
    localparam int MAX_FILTERS  = 16;
    localparam int MAX_CHANNELS = 8;
    localparam int MAX_NNZ      = 256;

    // table depths
    localparam int LAYER_TBL_DEPTH = MAX_LAYERS;
    localparam int NNZ_TBL_DEPTH   = MAX_LAYERS * MAX_CHANNELS;

    // index types
    typedef logic [$clog2(MAX_LAYERS)-1:0]   layer_idx_t;
    typedef logic [$clog2(MAX_FILTERS)-1:0]  filter_idx_t;
    typedef logic [$clog2(MAX_CHANNELS)-1:0] chan_idx_t;

    // position inside a compressed stream
    typedef logic [$clog2(MAX_NNZ)-1:0] nnz_idx_t;

    // a count of 1..MAX_NNZ needs one bit more than a position
    typedef logic [$clog2(MAX_NNZ):0] nnz_count_t;

    // filter and channel counts, both counted from 1
    typedef logic [$clog2(MAX_FILTERS):0]  filter_count_t;
    typedef logic [$clog2(MAX_CHANNELS):0] chan_count_t;

    // per-layer configuration, 18 bits
    // w_count is the compressed weight count of every channel of the layer
    typedef struct packed {
        filter_count_t num_filters;
        chan_count_t   num_chans;
        nnz_count_t    w_count;
    } layer_cfg_t;

    // control phases of the processing element
    typedef enum logic [2:0] {
        ph_idle   = 3'd0,
        ph_stream = 3'd1,
        ph_exec   = 3'd2,
        ph_drain  = 3'd3,
        ph_done   = 3'd4
    } phase_t;

endpackage

`default_nettype wire

//--- verilog/param_table.sv
`timescale 1ns/10ps
`default_nettype none

module param_table #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       we,
    input  wire  [$clog2(DEPTH)-1:0]  waddr,
    input  wire  [$clog2(DEPTH)-1:0]  raddr,
    input  entry_t                    wdata,
    output entry_t                    rdata
);

    entry_t mem [DEPTH];
    logic   rst_d;

    // the table is cleared on the first reset cycle only, so it can be
    // loaded while rst is still held
    always_ff @(posedge clk) begin
        rst_d <= rst;
        if (rst && !rst_d) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // asynchronous read
    assign rdata = mem[raddr];

    // non power-of-two depths leave unused addresses
    a_waddr_range: assert property (
        @(posedge clk) we |-> (int'(waddr) < DEPTH)
    ) else $error("param_table write beyond depth %0d", DEPTH);

endmodule

`default_nettype wire

//--- verilog/tile_walker.sv
`timescale 1ns/10ps
`default_nettype none

module tile_walker import pe_ctrl_pkg::*; #(
    parameter int TILE_W = 4,
    parameter int TILE_A = 4
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          sweep_start,
    input  wire          busy,
    input  layer_idx_t   cur_layer,
    input  filter_idx_t  cur_k,
    input  layer_cfg_t   layer_cfg,
    input  nnz_count_t   chan_nnz,
    output chan_idx_t    chan,
    output logic         tile_valid,
    output nnz_idx_t     tile_a,
    output nnz_idx_t     tile_w,
    output nnz_count_t   tile_a_count,
    output nnz_count_t   tile_w_count,
    output layer_idx_t   tile_layer,
    output filter_idx_t  tile_k,
    output logic         sweep_done
);

    logic       active;
    chan_idx_t  c;
    nnz_idx_t   a;
    nnz_idx_t   w;

    // positions after one more step, wide enough not to wrap
    logic [9:0] a_step;
    logic [9:0] w_step;
    logic       last_w;
    logic       last_a;
    logic       last_c;
    nnz_count_t rem_a;
    nnz_count_t rem_w;
    logic       issue;

    assign a_step = 10'(a) + 10'(TILE_A);
    assign w_step = 10'(w) + 10'(TILE_W);

    assign last_w = w_step >= 10'(layer_cfg.w_count);
    assign last_a = a_step >= 10'(chan_nnz);
    assign last_c = (chan_count_t'(c) + chan_count_t'(1)) == layer_cfg.num_chans;

    // remaining elements from the current position to the end of the channel
    assign rem_w = layer_cfg.w_count - nnz_count_t'(w);
    assign rem_a = chan_nnz - nnz_count_t'(a);

    assign tile_w_count = (rem_w < nnz_count_t'(TILE_W)) ? rem_w : nnz_count_t'(TILE_W);
    assign tile_a_count = (rem_a < nnz_count_t'(TILE_A)) ? rem_a : nnz_count_t'(TILE_A);

    // one tile per cycle, busy pauses the walk
    assign issue      = active && !busy;
    assign tile_valid = issue;

    assign tile_a     = a;
    assign tile_w     = w;
    assign tile_layer = cur_layer;
    assign tile_k     = cur_k;
    assign chan       = c;

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            sweep_done <= 1'b0;
            c          <= '0;
            a          <= '0;
            w          <= '0;
        end else begin
            sweep_done <= 1'b0;
            if (sweep_start) begin
                active <= 1'b1;
                c      <= '0;
                a      <= '0;
                w      <= '0;
            end else if (issue) begin
                // weight loop innermost, then activations, then channels
                if (!last_w) begin
                    w <= w_step[7:0];
                end else begin
                    w <= '0;
                    if (!last_a) begin
                        a <= a_step[7:0];
                    end else begin
                        a <= '0;
                        if (!last_c) begin
                            c <= c + chan_idx_t'(1);
                        end else begin
                            // last tile of the sweep
                            active     <= 1'b0;
                            sweep_done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // a busy cycle keeps the walk position, so no tile is lost or repeated
    a_hold_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        (active && busy) |=> (active && $stable(c) && $stable(a) && $stable(w))
    ) else $error("walker moved while busy");

endmodule

`default_nettype wire

//--- verilog/phase_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module phase_fsm import pe_ctrl_pkg::*; #(
    parameter int NUM_LAYERS = 3
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          filter_finish,
    input  wire          input_finish,
    input  wire          ppu_done,
    input  wire          xbar_empty,
    input  wire          sweep_done,
    input  layer_cfg_t   layer_cfg,
    output phase_t       phase,
    output layer_idx_t   cur_layer,
    output filter_idx_t  cur_k,
    output logic         sweep_start,
    output logic         req_filter,
    output logic         req_input,
    output logic         done
);

    phase_t next_phase;

    // sticky latches, cleared on every phase change
    logic fin_filter;
    logic fin_input;
    logic fin_ppu;
    logic seen_xbar;

    logic last_k;
    logic last_layer;
    logic final_k;
    logic stream_go;
    logic drain_go;

    assign last_k     = filter_count_t'(cur_k) == (layer_cfg.num_filters - filter_count_t'(1));
    assign last_layer = cur_layer == layer_idx_t'(NUM_LAYERS - 1);
    // last filter of the whole network, no further filter stream
    assign final_k    = last_k && last_layer;

    // stream waits for both latches, one cycle after the later pulse
    assign stream_go = fin_filter && fin_input;

    // drain: crossbar empty, PPU finished and next filter streamed in
    assign drain_go = (seen_xbar || xbar_empty) &&
                      (fin_ppu || ppu_done) &&
                      (final_k || fin_filter || filter_finish);

    always_comb begin
        next_phase = phase;
        case (phase)
            ph_idle: begin
                next_phase = ph_stream;
            end
            ph_stream: begin
                if (stream_go) begin
                    next_phase = ph_exec;
                end
            end
            ph_exec: begin
                if (sweep_done) begin
                    next_phase = ph_drain;
                end
            end
            ph_drain: begin
                if (drain_go) begin
                    next_phase = final_k ? ph_done : ph_exec;
                end
            end
            ph_done: begin
                next_phase = ph_done;
            end
            default: begin
                next_phase = ph_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase       <= ph_idle;
            cur_layer   <= '0;
            cur_k       <= '0;
            sweep_start <= 1'b0;
            fin_filter  <= 1'b0;
            fin_input   <= 1'b0;
            fin_ppu     <= 1'b0;
            seen_xbar   <= 1'b0;
        end else begin
            phase       <= next_phase;
            sweep_start <= (next_phase == ph_exec) && (phase != ph_exec);

            if (phase == ph_drain && drain_go && !final_k) begin
                if (last_k) begin
                    // next layer starts at filter 0, stream already requested
                    cur_layer <= cur_layer + layer_idx_t'(1);
                    cur_k     <= '0;
                end else begin
                    cur_k <= cur_k + filter_idx_t'(1);
                end
            end

            if (next_phase != phase) begin
                fin_filter <= 1'b0;
                fin_input  <= 1'b0;
                fin_ppu    <= 1'b0;
                seen_xbar  <= 1'b0;
            end else begin
                fin_filter <= fin_filter || filter_finish;
                fin_input  <= fin_input || input_finish;
                fin_ppu    <= fin_ppu || ppu_done;
                seen_xbar  <= seen_xbar || xbar_empty;
            end
        end
    end

    // requests drop once their finish pulse is latched
    assign req_input  = (phase == ph_stream) && !fin_input;
    assign req_filter = ((phase == ph_stream) && !fin_filter) ||
                        ((phase == ph_drain) && !final_k && !fin_filter);
    assign done       = phase == ph_done;

    // the walker only finishes a sweep that exec started
    a_sweep_done_in_exec: assert property (
        @(posedge clk) disable iff (rst)
        sweep_done |-> (phase == ph_exec)
    ) else $error("sweep_done outside exec");

endmodule

`default_nettype wire

//--- verilog/pe_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module pe_ctrl_top import pe_ctrl_pkg::*; #(
    parameter int TILE_W     = 4,
    parameter int TILE_A     = 4,
    parameter int NUM_LAYERS = 3
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          cfg_we,
    input  layer_idx_t   cfg_layer,
    input  layer_cfg_t   cfg_entry,
    input  wire          nnz_we,
    input  layer_idx_t   nnz_layer,
    input  chan_idx_t    nnz_chan,
    input  nnz_count_t   nnz_count,
    input  wire          busy,
    input  wire          filter_finish,
    input  wire          input_finish,
    input  wire          ppu_done,
    input  wire          xbar_empty,
    output logic         req_filter,
    output logic         req_input,
    output logic         tile_valid,
    output layer_idx_t   tile_layer,
    output filter_idx_t  tile_k,
    output chan_idx_t    tile_c,
    output nnz_idx_t     tile_a,
    output nnz_idx_t     tile_w,
    output nnz_count_t   tile_a_count,
    output nnz_count_t   tile_w_count,
    output logic         sweep_done,
    output logic         done
);

    phase_t      phase;
    layer_idx_t  cur_layer;
    filter_idx_t cur_k;
    logic        sweep_start;
    layer_cfg_t  layer_cfg;
    nnz_count_t  chan_nnz;
    chan_idx_t   chan;

    // count table index is layer*MAX_CHANNELS + chan
    param_table #(
        .entry_t (layer_cfg_t),
        .DEPTH   (LAYER_TBL_DEPTH)
    ) layer_table (
        .clk   (clk),
        .rst   (rst),
        .we    (cfg_we),
        .waddr (cfg_layer),
        .raddr (cur_layer),
        .wdata (cfg_entry),
        .rdata (layer_cfg)
    );

    param_table #(
        .entry_t (nnz_count_t),
        .DEPTH   (NNZ_TBL_DEPTH)
    ) nnz_table (
        .clk   (clk),
        .rst   (rst),
        .we    (nnz_we),
        .waddr ({nnz_layer, nnz_chan}),
        .raddr ({cur_layer, chan}),
        .wdata (nnz_count),
        .rdata (chan_nnz)
    );

    tile_walker #(
        .TILE_W (TILE_W),
        .TILE_A (TILE_A)
    ) walker (
        .clk          (clk),
        .rst          (rst),
        .sweep_start  (sweep_start),
        .busy         (busy),
        .cur_layer    (cur_layer),
        .cur_k        (cur_k),
        .layer_cfg    (layer_cfg),
        .chan_nnz     (chan_nnz),
        .chan         (chan),
        .tile_valid   (tile_valid),
        .tile_a       (tile_a),
        .tile_w       (tile_w),
        .tile_a_count (tile_a_count),
        .tile_w_count (tile_w_count),
        .tile_layer   (tile_layer),
        .tile_k       (tile_k),
        .sweep_done   (sweep_done)
    );

    phase_fsm #(
        .NUM_LAYERS (NUM_LAYERS)
    ) fsm (
        .clk           (clk),
        .rst           (rst),
        .filter_finish (filter_finish),
        .input_finish  (input_finish),
        .ppu_done      (ppu_done),
        .xbar_empty    (xbar_empty),
        .sweep_done    (sweep_done),
        .layer_cfg     (layer_cfg),
        .phase         (phase),
        .cur_layer     (cur_layer),
        .cur_k         (cur_k),
        .sweep_start   (sweep_start),
        .req_filter    (req_filter),
        .req_input     (req_input),
        .done          (done)
    );

    assign tile_c = chan;

    // tables feed the walker combinationally, so they only change at rest
    a_cfg_write_idle: assert property (
        @(posedge clk) (cfg_we || nnz_we) |-> (rst || phase == ph_idle)
    ) else $error("table write outside idle");

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over the first RST_CYCLES rising edges
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_pe_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pe_ctrl import pe_ctrl_pkg::*;;

    localparam int TILE_W     = 4;
    localparam int TILE_A     = 4;
    localparam int NUM_LAYERS = 3;
    localparam int TIMEOUT    = 20000;
    // table writes that fit between the first reset edge and the release of rst
    localparam int LOAD_SLOTS = 9;

    typedef struct packed {
        layer_idx_t  layer;
        filter_idx_t k;
        chan_idx_t   c;
        nnz_idx_t    a;
        nnz_idx_t    w;
        nnz_count_t  a_count;
        nnz_count_t  w_count;
    } tile_t;

    logic        clk;
    logic        rst;
    logic        cfg_we;
    layer_idx_t  cfg_layer;
    layer_cfg_t  cfg_entry;
    logic        nnz_we;
    layer_idx_t  nnz_layer;
    chan_idx_t   nnz_chan;
    nnz_count_t  nnz_count;
    logic        busy;
    logic        filter_finish;
    logic        input_finish;
    logic        ppu_done;
    logic        xbar_empty;
    logic        req_filter;
    logic        req_input;
    logic        tile_valid;
    layer_idx_t  tile_layer;
    filter_idx_t tile_k;
    chan_idx_t   tile_c;
    nnz_idx_t    tile_a;
    nnz_idx_t    tile_w;
    nnz_count_t  tile_a_count;
    nnz_count_t  tile_w_count;
    logic        sweep_done;
    logic        done;

    // layer configuration drawn at the start of the run
    int nf [NUM_LAYERS];
    int nc [NUM_LAYERS];
    int wc [NUM_LAYERS];
    int an [NUM_LAYERS][MAX_CHANNELS];
    int total_filters;

    tile_t exp_q[$];
    int    cyc;
    int    sweeps;
    int    last_layer_seen;
    int    last_k_seen;
    bit    run_over;
    bit    first_tile_seen;
    bit    saw_in_fin;
    bit    saw_fl_fin;
    // drain tracking between sweep_done and the next tile
    bit    after_sweep;
    bit    drain_first;
    bit    drain_xbar;
    bit    drain_ppu;
    bit    drain_filter;
    bit    need_filter;
    bit    drain_final;
    bit    fl_fin_prev;

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    pe_ctrl_top #(
        .TILE_W     (TILE_W),
        .TILE_A     (TILE_A),
        .NUM_LAYERS (NUM_LAYERS)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .cfg_we        (cfg_we),
        .cfg_layer     (cfg_layer),
        .cfg_entry     (cfg_entry),
        .nnz_we        (nnz_we),
        .nnz_layer     (nnz_layer),
        .nnz_chan      (nnz_chan),
        .nnz_count     (nnz_count),
        .busy          (busy),
        .filter_finish (filter_finish),
        .input_finish  (input_finish),
        .ppu_done      (ppu_done),
        .xbar_empty    (xbar_empty),
        .req_filter    (req_filter),
        .req_input     (req_input),
        .tile_valid    (tile_valid),
        .tile_layer    (tile_layer),
        .tile_k        (tile_k),
        .tile_c        (tile_c),
        .tile_a        (tile_a),
        .tile_w        (tile_w),
        .tile_a_count  (tile_a_count),
        .tile_w_count  (tile_w_count),
        .sweep_done    (sweep_done),
        .done          (done)
    );

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        abort_run();
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch(name, 32'(got), 32'(exp));
        end
    endtask

    task automatic check_tile(input tile_t exp, input layer_idx_t layer,
                              input filter_idx_t k, input chan_idx_t c,
                              input nnz_idx_t a, input nnz_idx_t w,
                              input nnz_count_t a_count, input nnz_count_t w_count);
        if (layer !== exp.layer) report_mismatch("tile_layer", 32'(layer), 32'(exp.layer));
        if (k !== exp.k) report_mismatch("tile_k", 32'(k), 32'(exp.k));
        if (c !== exp.c) report_mismatch("tile_c", 32'(c), 32'(exp.c));
        if (a !== exp.a) report_mismatch("tile_a", 32'(a), 32'(exp.a));
        if (w !== exp.w) report_mismatch("tile_w", 32'(w), 32'(exp.w));
        if (a_count !== exp.a_count) begin
            report_mismatch("tile_a_count", 32'(a_count), 32'(exp.a_count));
        end
        if (w_count !== exp.w_count) begin
            report_mismatch("tile_w_count", 32'(w_count), 32'(exp.w_count));
        end
    endtask

    // at most three channels per layer, so all count writes fit in LOAD_SLOTS
    function automatic void make_config();
        int l;
        int c;
        total_filters = 0;
        for (l = 0; l < NUM_LAYERS; l++) begin
            nf[l] = 1 + int'($urandom_range(3));
            nc[l] = 1 + int'($urandom_range(2));
            wc[l] = 1 + int'($urandom_range(19));
            total_filters += nf[l];
            for (c = 0; c < MAX_CHANNELS; c++) begin
                an[l][c] = 1 + int'($urandom_range(19));
            end
        end
    endfunction

    // expected tiles in the order layer, k, c, a, w
    function automatic int build_expected();
        tile_t t;
        int    l;
        int    k;
        int    c;
        int    a;
        int    w;
        for (l = 0; l < NUM_LAYERS; l++) begin
            for (k = 0; k < nf[l]; k++) begin
                for (c = 0; c < nc[l]; c++) begin
                    for (a = 0; a < an[l][c]; a += TILE_A) begin
                        for (w = 0; w < wc[l]; w += TILE_W) begin
                            t.layer   = layer_idx_t'(l);
                            t.k       = filter_idx_t'(k);
                            t.c       = chan_idx_t'(c);
                            t.a       = nnz_idx_t'(a);
                            t.w       = nnz_idx_t'(w);
                            t.a_count = nnz_count_t'((an[l][c] - a < TILE_A) ?
                                                     an[l][c] - a : TILE_A);
                            t.w_count = nnz_count_t'((wc[l] - w < TILE_W) ? wc[l] - w : TILE_W);
                            exp_q.push_back(t);
                        end
                    end
                end
            end
        end
        return exp_q.size();
    endfunction

    task automatic init_inputs();
        cfg_we        = 1'b0;
        cfg_layer     = '0;
        cfg_entry     = '0;
        nnz_we        = 1'b0;
        nnz_layer     = '0;
        nnz_chan      = '0;
        nnz_count     = '0;
        busy          = 1'b0;
        filter_finish = 1'b0;
        input_finish  = 1'b0;
        ppu_done      = 1'b0;
        xbar_empty    = 1'b0;
    endtask

    // called on the first reset edge, last write lands on the last reset edge
    task automatic load_tables();
        int         wl[$];
        int         wch[$];
        int         slot;
        int         l;
        int         c;
        layer_cfg_t entry;
        for (l = 0; l < NUM_LAYERS; l++) begin
            for (c = 0; c < nc[l]; c++) begin
                wl.push_back(l);
                wch.push_back(c);
            end
        end
        for (slot = 0; slot < LOAD_SLOTS; slot++) begin
            cfg_we <= (slot < NUM_LAYERS);
            nnz_we <= (slot < wl.size());
            if (slot < NUM_LAYERS) begin
                entry.num_filters = filter_count_t'(nf[slot]);
                entry.num_chans   = chan_count_t'(nc[slot]);
                entry.w_count     = nnz_count_t'(wc[slot]);
                cfg_layer <= layer_idx_t'(slot);
                cfg_entry <= entry;
            end
            if (slot < wl.size()) begin
                nnz_layer <= layer_idx_t'(wl[slot]);
                nnz_chan  <= chan_idx_t'(wch[slot]);
                nnz_count <= nnz_count_t'(an[wl[slot]][wch[slot]]);
            end
            @(posedge clk);
        end
        cfg_we <= 1'b0;
        nnz_we <= 1'b0;
    endtask

    task automatic drive_noise();
        while (!run_over) begin
            @(posedge clk);
            busy       <= ($urandom_range(99) < 30);
            xbar_empty <= 1'($urandom_range(1));
        end
    endtask

    function automatic logic req_level(input bit filter_side);
        return filter_side ? req_filter : req_input;
    endfunction

    // stream source, one finish pulse per request
    task automatic answer_requests(input bit filter_side);
        int waited;
        int delay;
        while (!run_over) begin
            waited = 0;
            @(posedge clk);
            while (!run_over && !req_level(filter_side)) begin
                if (waited >= TIMEOUT) report_failure("timeout waiting for a stream request");
                waited++;
                @(posedge clk);
            end
            if (!run_over) begin
                delay = 1 + int'($urandom_range(7));
                repeat (delay - 1) @(posedge clk);
                if (filter_side) filter_finish <= 1'b1;
                else input_finish <= 1'b1;
                @(posedge clk);
                if (filter_side) filter_finish <= 1'b0;
                else input_finish <= 1'b0;
                waited = 0;
                while (req_level(filter_side)) begin
                    if (waited >= TIMEOUT) report_failure("stream request stuck after finish");
                    waited++;
                    @(posedge clk);
                end
            end
        end
    endtask

    task automatic model_ppu();
        int waited;
        int delay;
        while (!run_over) begin
            waited = 0;
            @(posedge clk);
            while (!run_over && !sweep_done) begin
                if (waited >= TIMEOUT) report_failure("timeout waiting for sweep_done");
                waited++;
                @(posedge clk);
            end
            if (!run_over) begin
                delay = 2 + int'($urandom_range(8));
                repeat (delay - 1) @(posedge clk);
                ppu_done <= 1'b1;
                @(posedge clk);
                ppu_done <= 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        tile_t exp;
        if (rst) begin
            // nothing is defined before the first reset edge
            if (cyc > 0) begin
                check_flag("tile_valid", tile_valid, 1'b0);
                check_flag("req_filter", req_filter, 1'b0);
                check_flag("req_input", req_input, 1'b0);
                check_flag("sweep_done", sweep_done, 1'b0);
                check_flag("done", done, 1'b0);
            end
        end else begin
            if (!first_tile_seen) begin
                if (input_finish && req_input) saw_in_fin = 1'b1;
                if (filter_finish && req_filter) saw_fl_fin = 1'b1;
            end
            if (tile_valid) begin
                if (busy) report_failure("tile issued while busy was high");
                if (!saw_in_fin || !saw_fl_fin) begin
                    report_failure("first tile came before both stream finish pulses");
                end
                if (after_sweep) begin
                    if (!drain_xbar || !drain_ppu) begin
                        report_failure("tile came before xbar_empty and ppu_done in drain");
                    end
                    if (need_filter && !drain_filter) begin
                        report_failure("tile came before filter_finish in drain");
                    end
                    after_sweep = 1'b0;
                end
                if (exp_q.size() == 0) report_failure("tile beyond the expected list");
                exp = exp_q.pop_front();
                check_tile(exp, tile_layer, tile_k, tile_c, tile_a, tile_w,
                           tile_a_count, tile_w_count);
                first_tile_seen = 1'b1;
                last_layer_seen = int'(exp.layer);
                last_k_seen     = int'(exp.k);
            end
            if (after_sweep) begin
                if (drain_first) begin
                    check_flag("req_filter", req_filter, !drain_final);
                end else if (fl_fin_prev || drain_final) begin
                    check_flag("req_filter", req_filter, 1'b0);
                end
                drain_first = 1'b0;
                if (xbar_empty) drain_xbar = 1'b1;
                if (ppu_done) drain_ppu = 1'b1;
                if (filter_finish) drain_filter = 1'b1;
                fl_fin_prev = filter_finish;
            end
            if (sweep_done) begin
                sweeps++;
                after_sweep  = 1'b1;
                drain_first  = 1'b1;
                drain_xbar   = 1'b0;
                drain_ppu    = 1'b0;
                drain_filter = 1'b0;
                fl_fin_prev  = 1'b0;
                need_filter  = (last_k_seen != nf[last_layer_seen] - 1);
                drain_final  = !need_filter && (last_layer_seen == NUM_LAYERS - 1);
            end
        end
        cyc++;
    end

    initial begin
        int waited;
        int settle;
        int total_tiles;
        init_inputs();
        void'($urandom(32'h5ebe58ef));
        make_config();
        total_tiles = build_expected();
        $display("expecting %0d tiles over %0d filters", total_tiles, total_filters);
        fork
            drive_noise();
            answer_requests(1'b1);
            answer_requests(1'b0);
            model_ppu();
        join_none
        @(posedge clk);
        load_tables();
        waited = 0;
        while (!done) begin
            if (waited >= TIMEOUT) report_failure("timeout waiting for done");
            waited++;
            @(posedge clk);
        end
        // done holds and nothing more is requested
        for (settle = 0; settle < 4; settle++) begin
            @(posedge clk);
            check_flag("done", done, 1'b1);
            check_flag("req_filter", req_filter, 1'b0);
            check_flag("req_input", req_input, 1'b0);
        end
        run_over = 1'b1;
        if (exp_q.size() == 0 && sweeps == total_filters && drain_ppu && drain_xbar) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("ERROR at %0t ns: %0d tiles left, %0d of %0d sweeps, last drain open",
                     $time, exp_q.size(), sweeps, total_filters);
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- src.f
verilog/pe_ctrl_pkg.sv
verilog/param_table.sv
verilog/tile_walker.sv
verilog/phase_fsm.sv
verilog/pe_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/tb_pe_ctrl.sv

//--- Makefile
TOP := tb_pe_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
